// ==== rtl/zap_operand_pkg.sv ====
package zap_operand_pkg;

        // ==============================
        // Operand source words.
        // ==============================

        // Flag value that marks an immediate operand.
        localparam logic IMMED_EN = 1'b1;

        // Operand word read as an immediate.
        typedef struct packed {
                logic        flag;
                logic [31:0] value;
        } imm_word_t;

        // Operand word read as a register selector.
        typedef struct packed {
                logic        flag;
                logic [31:0] index;
        } reg_word_t;

        typedef union packed {
                imm_word_t imm;
                reg_word_t regsel;
        } operand_src_t;

        // ==============================
        // Condition codes.
        // ==============================

        typedef logic [3:0] cond_t;

        // Never executes. Also marks an empty stage slot.
        localparam cond_t CC_NV = 4'hF;

endpackage

// ==== rtl/zap_shift_pkg.sv ====
package zap_shift_pkg;

        // ==============================
        // Shift operations.
        // ==============================

        typedef logic [2:0] shift_op_t;

        // Logical shift left.
        localparam shift_op_t SH_LSL = 3'd0;

        // Logical shift right.
        localparam shift_op_t SH_LSR = 3'd1;

        // Arithmetic shift right.
        localparam shift_op_t SH_ASR = 3'd2;

        // Rotate right.
        localparam shift_op_t SH_ROR = 3'd3;

        // Rotate right by one through carry.
        localparam shift_op_t SH_RRX = 3'd4;

        // ==============================
        // Shift amount.
        // ==============================

        // Low byte of the shift length register.
        typedef logic [7:0] shift_amt_t;

endpackage

// ==== rtl/zap_barrel_shifter.sv ====
`timescale 1ns/10ps

module zap_barrel_shifter
(
        input  logic [31:0]               i_source,
        input  zap_shift_pkg::shift_amt_t i_amount,
        input  zap_shift_pkg::shift_op_t  i_shift_type,
        output logic [31:0]               o_result,
        output logic                      o_carry,
        output logic                      o_rrx,
        output logic                      o_use_old_carry
);

        // Shifts widened by one bit so the carry falls out alongside.
        logic        [32:0] lsl_ext;
        logic        [32:0] lsr_ext;
        logic signed [32:0] asr_ext;
        logic        [63:0] ror_ext;
        logic               zero_amount;

        assign zero_amount = (i_amount == '0);

        // Carry lands in bit 32, zero past 32 places.
        assign lsl_ext = {1'b0, i_source} << i_amount;

        // Carry lands in bit 0, zero past 32 places.
        assign lsr_ext = {i_source, 1'b0} >> i_amount;

        // Saturates to all sign bits past 32 places.
        assign asr_ext = $signed({i_source, 1'b0}) >>> i_amount;

        // Only the amount modulo 32 matters for a rotate.
        assign ror_ext = {i_source, i_source} >> i_amount[4:0];

        always_comb
        begin
                o_result        = i_source;
                o_carry         = 1'b0;
                o_rrx           = 1'b0;
                o_use_old_carry = 1'b0;

                case (i_shift_type)
                        zap_shift_pkg::SH_LSR:
                        begin
                                o_result = lsr_ext[32:1];
                                o_carry  = lsr_ext[0];
                        end
                        zap_shift_pkg::SH_ASR:
                        begin
                                o_result = asr_ext[32:1];
                                o_carry  = asr_ext[0];
                        end
                        zap_shift_pkg::SH_ROR:
                        begin
                                // Bit (n-1) mod 32 ends up on top after the rotate.
                                o_result = ror_ext[31:0];
                                o_carry  = ror_ext[31];
                        end
                        zap_shift_pkg::SH_RRX:
                        begin
                                // ALU fills bit 31 with the old carry.
                                o_result = {1'b0, i_source[31:1]};
                                o_carry  = i_source[0];
                                o_rrx    = 1'b1;
                        end
                        default:
                        begin
                                o_result = lsl_ext[31:0];
                                o_carry  = lsl_ext[32];
                        end
                endcase

                // Zero amount passes the source, ALU keeps its carry.
                if (zero_amount && (i_shift_type != zap_shift_pkg::SH_RRX))
                begin
                        o_result        = i_source;
                        o_carry         = 1'b0;
                        o_use_old_carry = 1'b1;
                end
        end

endmodule

// ==== rtl/zap_operand_resolver.sv ====
`timescale 1ns/10ps

module zap_operand_resolver
#(
        parameter int PHY_REGS = 46
)
(
        input  zap_operand_pkg::operand_src_t   i_alu_source,
        input  zap_operand_pkg::operand_src_t   i_shift_source,
        input  zap_operand_pkg::operand_src_t   i_mem_srcdest,
        input  logic [31:0]                     i_alu_source_value,
        input  logic [31:0]                     i_shift_source_value,
        input  logic [31:0]                     i_mem_srcdest_value,
        input  logic [$clog2(PHY_REGS)-1:0]     i_stage_destination_index,
        input  zap_operand_pkg::cond_t          i_stage_condition_code,
        input  logic [31:0]                     i_alu_value_nxt,
        output logic [31:0]                     o_alu_source_value,
        output logic [31:0]                     o_shift_source_value,
        output logic [31:0]                     o_mem_srcdest_value
);

        localparam int IDX_W = $clog2(PHY_REGS);

        logic stage_live;

        // A cleared or empty slot never forwards.
        assign stage_live = (i_stage_condition_code != zap_operand_pkg::CC_NV);

        // Immediate first, then the ALU result in flight, then the issue read.
        function automatic logic [31:0] resolve
        (
                input zap_operand_pkg::operand_src_t src,
                input logic [31:0]                   issue_value
        );
                logic [IDX_W-1:0] src_index;

                src_index = src.regsel.index[IDX_W-1:0];
                if (src.imm.flag == zap_operand_pkg::IMMED_EN)
                begin
                        return src.imm.value;
                end
                else if (stage_live && (src_index == i_stage_destination_index))
                begin
                        return i_alu_value_nxt;
                end
                else
                begin
                        return issue_value;
                end
        endfunction

        always_comb
        begin
                o_alu_source_value   = resolve(i_alu_source, i_alu_source_value);
                o_shift_source_value = resolve(i_shift_source, i_shift_source_value);
                o_mem_srcdest_value  = resolve(i_mem_srcdest, i_mem_srcdest_value);
        end

        // Stage register must only ever hold a real physical register.
        a_stage_index_range: assert final ($isunknown(i_stage_destination_index) ||
                (i_stage_destination_index < PHY_REGS));

endmodule

// ==== rtl/zap_shift_stage_reg.sv ====
`timescale 1ns/10ps

module zap_shift_stage_reg
#(
        parameter int PHY_REGS = 46,
        parameter int ALU_OPS  = 32
)
(
        input  logic                            i_clk,
        input  logic                            i_reset,

        // ==============================
        // Clear and stall.
        // ==============================
        input  logic                            i_clear_from_writeback,
        input  logic                            i_data_stall,
        input  logic                            i_clear_from_alu,

        // ==============================
        // Shifter and resolver results.
        // ==============================
        input  logic                            i_disable_shifter,
        input  logic [31:0]                     i_shifter_result,
        input  logic                            i_shifter_carry,
        input  logic                            i_shifter_rrx,
        input  logic                            i_shifter_use_old_carry,
        input  logic [31:0]                     i_resolved_alu_value,
        input  logic [31:0]                     i_resolved_shift_value,
        input  logic [31:0]                     i_resolved_mem_value,

        // ==============================
        // Pass-through fields.
        // ==============================
        input  zap_operand_pkg::cond_t          i_condition_code,
        input  logic [$clog2(PHY_REGS)-1:0]     i_destination_index,
        input  logic [$clog2(ALU_OPS)-1:0]      i_alu_operation,
        input  zap_shift_pkg::shift_op_t        i_shift_operation,
        input  logic                            i_flag_update,
        input  logic [$clog2(PHY_REGS)-1:0]     i_mem_srcdest_index,

        // ==============================
        // Registered outputs.
        // ==============================
        output logic [31:0]                     o_alu_source_value,
        output logic [31:0]                     o_shifted_source_value,
        output logic [31:0]                     o_mem_srcdest_value,
        output logic                            o_shift_carry,
        output logic                            o_rrx,
        output logic                            o_use_old_carry,
        output zap_operand_pkg::cond_t          o_condition_code,
        output logic [$clog2(PHY_REGS)-1:0]     o_destination_index,
        output logic [$clog2(ALU_OPS)-1:0]      o_alu_operation,
        output zap_shift_pkg::shift_op_t        o_shift_operation,
        output logic                            o_flag_update,
        output logic [$clog2(PHY_REGS)-1:0]     o_mem_srcdest_index
);

        logic [31:0] shift_value_nxt;
        logic        shift_carry_nxt;
        logic        rrx_nxt;
        logic        use_old_carry_nxt;
        logic        stage_clear;

        // Disabled shifter sends the resolved operand through unchanged.
        always_comb
        begin
                if (i_disable_shifter)
                begin
                        shift_value_nxt   = i_resolved_shift_value;
                        shift_carry_nxt   = 1'b0;
                        rrx_nxt           = 1'b0;
                        use_old_carry_nxt = 1'b1;
                end
                else
                begin
                        shift_value_nxt   = i_shifter_result;
                        shift_carry_nxt   = i_shifter_carry;
                        rrx_nxt           = i_shifter_rrx;
                        use_old_carry_nxt = i_shifter_use_old_carry;
                end
        end

        // Writeback clear beats stall, stall beats ALU clear.
        assign stage_clear = i_reset || i_clear_from_writeback ||
                             (!i_data_stall && i_clear_from_alu);

        always_ff @(posedge i_clk)
        begin
                if (stage_clear)
                begin
                        o_alu_source_value     <= '0;
                        o_shifted_source_value <= '0;
                        o_mem_srcdest_value    <= '0;
                        o_shift_carry          <= 1'b0;
                        o_rrx                  <= 1'b0;
                        o_use_old_carry        <= 1'b0;
                        o_condition_code       <= zap_operand_pkg::CC_NV;
                        o_destination_index    <= '0;
                        o_alu_operation        <= '0;
                        o_shift_operation      <= '0;
                        o_flag_update          <= 1'b0;
                        o_mem_srcdest_index    <= '0;
                end
                else if (!i_data_stall)
                begin
                        o_alu_source_value     <= i_resolved_alu_value;
                        o_shifted_source_value <= shift_value_nxt;
                        o_mem_srcdest_value    <= i_resolved_mem_value;
                        o_shift_carry          <= shift_carry_nxt;
                        o_rrx                  <= rrx_nxt;
                        o_use_old_carry        <= use_old_carry_nxt;
                        o_condition_code       <= i_condition_code;
                        o_destination_index    <= i_destination_index;
                        o_alu_operation        <= i_alu_operation;
                        o_shift_operation      <= i_shift_operation;
                        o_flag_update          <= i_flag_update;
                        o_mem_srcdest_index    <= i_mem_srcdest_index;
                end
        end

        // ==============================
        // Assertions.
        // ==============================

        // Writeback flush leaves an empty slot even under a stall.
        a_wb_clear_empties: assert property (@(posedge i_clk) disable iff (i_reset)
                i_clear_from_writeback |=> (o_condition_code == zap_operand_pkg::CC_NV));

        // A stall freezes the whole register.
        a_stall_holds: assert property (@(posedge i_clk) disable iff (i_reset)
                (i_data_stall && !i_clear_from_writeback) |=>
                $stable({o_alu_source_value, o_shifted_source_value, o_mem_srcdest_value,
                         o_shift_carry, o_rrx, o_use_old_carry, o_condition_code,
                         o_destination_index, o_alu_operation, o_shift_operation,
                         o_flag_update, o_mem_srcdest_index}));

endmodule

// ==== rtl/zap_shift_top.sv ====
`timescale 1ns/10ps

module zap_shift_top
#(
        parameter int PHY_REGS = 46,
        parameter int ALU_OPS  = 32
)
(
        input  logic                            i_clk,
        input  logic                            i_reset,
        input  logic                            i_clear_from_writeback,
        input  logic                            i_data_stall,
        input  logic                            i_clear_from_alu,
        input  logic                            i_disable_shifter,

        // Operand words and their issue reads.
        input  zap_operand_pkg::operand_src_t   i_alu_source,
        input  zap_operand_pkg::operand_src_t   i_shift_source,
        input  zap_operand_pkg::operand_src_t   i_mem_srcdest,
        input  logic [31:0]                     i_alu_source_value,
        input  logic [31:0]                     i_shift_source_value,
        input  logic [31:0]                     i_shift_length_value,
        input  logic [31:0]                     i_mem_srcdest_value,
        input  logic [31:0]                     i_alu_value_nxt,

        input  zap_operand_pkg::cond_t          i_condition_code,
        input  logic [$clog2(PHY_REGS)-1:0]     i_destination_index,
        input  logic [$clog2(ALU_OPS)-1:0]      i_alu_operation,
        input  zap_shift_pkg::shift_op_t        i_shift_operation,
        input  logic                            i_flag_update,
        input  logic [$clog2(PHY_REGS)-1:0]     i_mem_srcdest_index,

        output logic [31:0]                     o_alu_source_value,
        output logic [31:0]                     o_shifted_source_value,
        output logic [31:0]                     o_mem_srcdest_value,
        output logic                            o_shift_carry,
        output logic                            o_rrx,
        output logic                            o_use_old_carry,
        output zap_operand_pkg::cond_t          o_condition_code,
        output logic [$clog2(PHY_REGS)-1:0]     o_destination_index,
        output logic [$clog2(ALU_OPS)-1:0]      o_alu_operation,
        output zap_shift_pkg::shift_op_t        o_shift_operation,
        output logic                            o_flag_update,
        output logic [$clog2(PHY_REGS)-1:0]     o_mem_srcdest_index
);

        logic [31:0] shifter_result;
        logic        shifter_carry;
        logic        shifter_rrx;
        logic        shifter_use_old_carry;
        logic [31:0] resolved_alu_value;
        logic [31:0] resolved_shift_value;
        logic [31:0] resolved_mem_value;

        // Shift amount is the low byte of the length register.
        zap_barrel_shifter u_barrel_shifter
        (
                .i_source        (resolved_shift_value),
                .i_amount        (i_shift_length_value[7:0]),
                .i_shift_type    (i_shift_operation),
                .o_result        (shifter_result),
                .o_carry         (shifter_carry),
                .o_rrx           (shifter_rrx),
                .o_use_old_carry (shifter_use_old_carry)
        );

        // Compares against this stage's own output register.
        zap_operand_resolver #(.PHY_REGS(PHY_REGS)) u_operand_resolver
        (
                .i_alu_source              (i_alu_source),
                .i_shift_source            (i_shift_source),
                .i_mem_srcdest             (i_mem_srcdest),
                .i_alu_source_value        (i_alu_source_value),
                .i_shift_source_value      (i_shift_source_value),
                .i_mem_srcdest_value       (i_mem_srcdest_value),
                .i_stage_destination_index (o_destination_index),
                .i_stage_condition_code    (o_condition_code),
                .i_alu_value_nxt           (i_alu_value_nxt),
                .o_alu_source_value        (resolved_alu_value),
                .o_shift_source_value      (resolved_shift_value),
                .o_mem_srcdest_value       (resolved_mem_value)
        );

        zap_shift_stage_reg #(.PHY_REGS(PHY_REGS), .ALU_OPS(ALU_OPS)) u_stage_reg
        (
                .i_clk                   (i_clk),
                .i_reset                 (i_reset),
                .i_clear_from_writeback  (i_clear_from_writeback),
                .i_data_stall            (i_data_stall),
                .i_clear_from_alu        (i_clear_from_alu),
                .i_disable_shifter       (i_disable_shifter),
                .i_shifter_result        (shifter_result),
                .i_shifter_carry         (shifter_carry),
                .i_shifter_rrx           (shifter_rrx),
                .i_shifter_use_old_carry (shifter_use_old_carry),
                .i_resolved_alu_value    (resolved_alu_value),
                .i_resolved_shift_value  (resolved_shift_value),
                .i_resolved_mem_value    (resolved_mem_value),
                .i_condition_code        (i_condition_code),
                .i_destination_index     (i_destination_index),
                .i_alu_operation         (i_alu_operation),
                .i_shift_operation       (i_shift_operation),
                .i_flag_update           (i_flag_update),
                .i_mem_srcdest_index     (i_mem_srcdest_index),
                .o_alu_source_value      (o_alu_source_value),
                .o_shifted_source_value  (o_shifted_source_value),
                .o_mem_srcdest_value     (o_mem_srcdest_value),
                .o_shift_carry           (o_shift_carry),
                .o_rrx                   (o_rrx),
                .o_use_old_carry         (o_use_old_carry),
                .o_condition_code        (o_condition_code),
                .o_destination_index     (o_destination_index),
                .o_alu_operation         (o_alu_operation),
                .o_shift_operation       (o_shift_operation),
                .o_flag_update           (o_flag_update),
                .o_mem_srcdest_index     (o_mem_srcdest_index)
        );

endmodule

// ==== sim/zap_shift_model.svh ====
`ifndef ZAP_SHIFT_MODEL_SVH
`define ZAP_SHIFT_MODEL_SVH

// ==============================
// Reference constants.
// ==============================

localparam logic [2:0] OP_LSL = 3'd0;
localparam logic [2:0] OP_LSR = 3'd1;
localparam logic [2:0] OP_ASR = 3'd2;
localparam logic [2:0] OP_ROR = 3'd3;
localparam logic [2:0] OP_RRX = 3'd4;
localparam logic [3:0] NV_CODE = 4'hF;

// Packs {result, carry, rrx, use_old_carry}.
function automatic logic [34:0] expect_shift
(
        input logic [31:0] src,
        input logic [7:0]  n,
        input logic [2:0]  op
);
        logic [31:0] res;
        logic        c;
        logic        rrx;
        logic        uoc;
        int          k;

        res = src;
        c   = 1'b0;
        rrx = 1'b0;
        uoc = 1'b0;
        k   = n % 32;
        if (op == OP_RRX)
        begin
                res = {1'b0, src[31:1]};
                c   = src[0];
                rrx = 1'b1;
        end
        else if (n == 0)
        begin
                uoc = 1'b1;
        end
        else if (op == OP_LSR)
        begin
                res = (n < 32) ? (src >> n) : 32'd0;
                c   = (n < 32) ? src[n - 1] : ((n == 32) ? src[31] : 1'b0);
        end
        else if (op == OP_ASR)
        begin
                // Sign bits fill from the top.
                if (n < 32)
                        res = $signed(src) >>> n;
                else
                        res = {32{src[31]}};
                c   = (n < 32) ? src[n - 1] : src[31];
        end
        else if (op == OP_ROR)
        begin
                res = (k == 0) ? src : ((src >> k) | (src << (32 - k)));
                c   = (k == 0) ? src[31] : src[k - 1];
        end
        else
        begin
                // Unknown codes behave as LSL.
                res = (n < 32) ? (src << n) : 32'd0;
                c   = (n < 32) ? src[32 - n] : ((n == 32) ? src[0] : 1'b0);
        end
        return {res, c, rrx, uoc};
endfunction

// Immediate, then forward from a live stage slot, then issue value.
function automatic logic [31:0] expect_operand
(
        input logic [32:0] word,
        input logic [31:0] issue,
        input logic [31:0] alu_nxt,
        input logic [5:0]  stage_idx,
        input logic [3:0]  stage_cc
);
        if (word[32])
                return word[31:0];
        if ((stage_cc != NV_CODE) && (word[5:0] == stage_idx))
                return alu_nxt;
        return issue;
endfunction

`endif

// ==== sim/zap_shift_tb.sv ====
`timescale 1ns/10ps

module zap_shift_tb;

        `include "zap_shift_model.svh"

        logic        clk, reset, clear_wb, stall, clear_alu, disable_sh, flag_upd;
        logic [32:0] alu_src, shift_src, mem_src;
        logic [31:0] alu_val, shift_val, len_val, mem_val, alu_nxt;
        logic [3:0]  cc;
        logic [5:0]  dest, mem_idx;
        logic [4:0]  alu_op;
        logic [2:0]  sh_op;
        integer      seed;
        integer      wait_count;
        logic [34:0] sh;

        // DUT outputs and the model of the output register.
        logic [31:0] d_alu, d_shift, d_mem, m_alu, m_shift, m_mem;
        logic        d_carry, d_rrx, d_uoc, d_flag, m_carry, m_rrx, m_uoc, m_flag;
        logic [3:0]  d_cc, m_cc;
        logic [5:0]  d_dest, d_midx, m_dest, m_midx;
        logic [4:0]  d_aop, m_aop;
        logic [2:0]  d_sop, m_sop;

        zap_shift_top #(.PHY_REGS(46), .ALU_OPS(32)) zap_shift_top_inst
        (
                .i_clk(clk), .i_reset(reset), .i_clear_from_writeback(clear_wb),
                .i_data_stall(stall), .i_clear_from_alu(clear_alu),
                .i_disable_shifter(disable_sh), .i_alu_source(alu_src),
                .i_shift_source(shift_src), .i_mem_srcdest(mem_src),
                .i_alu_source_value(alu_val), .i_shift_source_value(shift_val),
                .i_shift_length_value(len_val), .i_mem_srcdest_value(mem_val),
                .i_alu_value_nxt(alu_nxt), .i_condition_code(cc), .i_destination_index(dest),
                .i_alu_operation(alu_op), .i_shift_operation(sh_op), .i_flag_update(flag_upd),
                .i_mem_srcdest_index(mem_idx), .o_alu_source_value(d_alu),
                .o_shifted_source_value(d_shift), .o_mem_srcdest_value(d_mem),
                .o_shift_carry(d_carry), .o_rrx(d_rrx), .o_use_old_carry(d_uoc),
                .o_condition_code(d_cc), .o_destination_index(d_dest),
                .o_alu_operation(d_aop), .o_shift_operation(d_sop),
                .o_flag_update(d_flag), .o_mem_srcdest_index(d_midx)
        );

        always #10 clk = ~clk;

        task automatic report_failure(input string msg);
                $display("%s", msg);
                $display("TB FAILED");
                $fatal(1);
        endtask

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                if (got !== exp)
                        report_failure($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
        endtask

        task automatic clear_model();
                {m_alu, m_shift, m_mem, m_carry, m_rrx, m_uoc} = '0;
                {m_dest, m_aop, m_sop, m_flag, m_midx} = '0;
                m_cc = NV_CODE;
        endtask

        task automatic check_outputs();
                check_value("o_alu_source_value", d_alu, m_alu);
                check_value("o_shifted_source_value", d_shift, m_shift);
                check_value("o_mem_srcdest_value", d_mem, m_mem);
                check_value("o_shift_carry", d_carry, m_carry);
                check_value("o_rrx", d_rrx, m_rrx);
                check_value("o_use_old_carry", d_uoc, m_uoc);
                check_value("o_condition_code", d_cc, m_cc);
                check_value("o_destination_index", d_dest, m_dest);
                check_value("o_alu_operation", d_aop, m_aop);
                check_value("o_shift_operation", d_sop, m_sop);
                check_value("o_flag_update", d_flag, m_flag);
                check_value("o_mem_srcdest_index", d_midx, m_midx);
        endtask

        // Boundary amounts around the 32-bit word.
        function automatic logic [7:0] directed_shift_amount(input int i);
                case (i)
                        0:       return 8'd0;
                        1:       return 8'd32;
                        2:       return 8'd33;
                        3:       return 8'd255;
                        default: return 8'd7;
                endcase
        endfunction

        // Index fields stay in 0..3 so forwarding matches are frequent.
        function automatic logic [32:0] random_operand(input logic imm);
                logic [31:0] r;

                r = $random(seed);
                return {imm, r[31:6], 4'd0, r[1:0]};
        endfunction

        task automatic drive_random();
                logic [31:0] r;

                r         = $random(seed);
                clear_wb  = (r[2:0] == 3'd0);
                stall     = (r[5:3] == 3'd0);
                clear_alu = (r[8:6] == 3'd0);
                disable_sh = (r[10:9] == 2'd0);
                alu_src   = random_operand(r[12:11] == 2'd0);
                shift_src = random_operand(r[14:13] == 2'd0);
                mem_src   = random_operand(r[16:15] == 2'd0);
                cc        = r[17] ? NV_CODE : r[21:18];
                dest      = {4'd0, r[23:22]};
                mem_idx   = r[29:24];
                flag_upd  = r[30];
                len_val   = r[31] ? $random(seed) : ($random(seed) & 32'h3F);
                sh_op     = $random(seed);
                alu_op    = $random(seed);
                alu_val   = $random(seed);
                shift_val = $random(seed);
                mem_val   = $random(seed);
                alu_nxt   = $random(seed);
        endtask

        // Loads the model on the rising edge, then checks on the falling edge.
        task automatic step();
                logic [31:0] n_alu, n_shift, n_mem;

                n_alu   = expect_operand(alu_src, alu_val, alu_nxt, m_dest, m_cc);
                n_shift = expect_operand(shift_src, shift_val, alu_nxt, m_dest, m_cc);
                n_mem   = expect_operand(mem_src, mem_val, alu_nxt, m_dest, m_cc);
                sh      = disable_sh ? {n_shift, 3'b001} : expect_shift(n_shift, len_val[7:0], sh_op);
                @(posedge clk);
                if (reset || clear_wb || (!stall && clear_alu))
                        clear_model();
                else if (!stall)
                begin
                        {m_alu, m_mem, m_cc, m_dest, m_aop} = {n_alu, n_mem, cc, dest, alu_op};
                        {m_shift, m_carry, m_rrx, m_uoc} = sh;
                        {m_sop, m_flag, m_midx} = {sh_op, flag_upd, mem_idx};
                end
                @(negedge clk);
                check_outputs();
        endtask

        initial
        begin
                seed = 32'h9c6c;
                clk  = 1'b0;
                reset = 1'b1;
                drive_random();
                {clear_wb, stall, clear_alu, disable_sh} = '0;
                repeat (2) @(posedge clk);
                wait_count = 0;
                @(negedge clk);
                while (d_cc !== NV_CODE)
                begin
                        wait_count = wait_count + 1;
                        if (wait_count > 16)
                                report_failure("Timeout waiting for the stage register to reset.");
                        @(negedge clk);
                end
                reset = 1'b0;
                clear_model();
                check_outputs();

                // ==============================
                // Directed shift amounts.
                // ==============================
                for (int op = 0; op < 5; op++)
                begin
                        for (int i = 0; i < 5; i++)
                        begin
                                drive_random();
                                {clear_wb, stall, clear_alu, disable_sh} = '0;
                                shift_src = random_operand(1'b1);
                                sh_op   = op;
                                len_val = {len_val[31:8], directed_shift_amount(i)};
                                step();
                        end
                end

                // ==============================
                // Random traffic.
                // ==============================
                repeat (600)
                begin
                        drive_random();
                        step();
                end

                // Clear priority against stall, starting from a loaded slot.
                drive_random();
                {clear_wb, stall, clear_alu} = 3'b000;
                step();
                drive_random();
                {clear_wb, stall, clear_alu} = 3'b011;
                step();
                drive_random();
                {clear_wb, stall, clear_alu} = 3'b111;
                step();
                drive_random();
                {clear_wb, stall, clear_alu} = 3'b000;
                step();
                drive_random();
                {clear_wb, stall, clear_alu} = 3'b001;
                step();

                $display("TB PASSED");
                $finish;
        end

endmodule

// ==== sources.f ====
+incdir+sim
rtl/zap_operand_pkg.sv
rtl/zap_shift_pkg.sv
rtl/zap_barrel_shifter.sv
rtl/zap_operand_resolver.sv
rtl/zap_shift_stage_reg.sv
rtl/zap_shift_top.sv
sim/zap_shift_tb.sv

// ==== Bender.yml ====
package:
  name: zap_shift_stage

sources:
  - rtl/zap_operand_pkg.sv
  - rtl/zap_shift_pkg.sv
  - rtl/zap_barrel_shifter.sv
  - rtl/zap_operand_resolver.sv
  - rtl/zap_shift_stage_reg.sv
  - rtl/zap_shift_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/zap_shift_tb.sv
